// ==== list.f ====
+incdir+tb
src/cpu_pkg.sv
src/cpu_alu.sv
src/cpu_pcu.sv
src/cpu_ccu.sv
src/cpu_top.sv
tb/tb_cpu.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_cpu
FILELIST = list.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== tb/tb_cpu_model.svh ====
// **************************************************************************
// Random program generator and instruction-level reference model for the
// 8-bit CPU testbench
// **************************************************************************

`ifndef TB_CPU_MODEL_SVH
`define TB_CPU_MODEL_SVH

localparam logic [31:0]    lcg_seed  = 32'h88583fc5;
// Stores land in the upper half, code stays below it
localparam cpu_pkg::byte_t data_base = 8'h80;

logic [31:0]    lcg_state;
cpu_pkg::byte_t prog_mem  [0:255];
cpu_pkg::byte_t model_mem [0:255];
// Expected bus cycles as {r_w, addr, data}, data is zero for reads
logic [16:0]    exp_bus [$];
int             exp_writes;
logic           exp_error;

function automatic logic [31:0] lcg_next();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state;
endfunction

// Upper bits of the LCG are the better mixed ones
function automatic cpu_pkg::byte_t rand_byte();
	logic [31:0] w;
	w = lcg_next();
	return w[31:24];
endfunction

function automatic int unsigned rand_below(input int unsigned n);
	logic [31:0] w;
	int unsigned hi;
	w = lcg_next();
	hi = {16'h0, w[31:16]};
	return hi % n;
endfunction

// **************************************************************************
// Program generator
// **************************************************************************

function automatic void gen_program(input int n, input logic end_illegal);
	int             i;
	int unsigned    k;
	int unsigned    lim;
	logic [3:0]     op;
	cpu_pkg::byte_t b;
	cpu_pkg::byte_t arg;
	// Random background, data reads hit whatever is there
	for (i = 0; i < 256; i++)
		prog_mem[i] = rand_byte();
	for (i = 0; i < n - 1; i++) begin
		k   = rand_below(13);
		op  = k[3:0];
		arg = rand_byte();
		case (op)
			cpu_pkg::sta_mem, cpu_pkg::stx_mem: arg = data_base | arg;
			cpu_pkg::jmp, cpu_pkg::jz, cpu_pkg::jc: begin
				// Short forward hop onto an instruction boundary
				lim = n - 1 - i;
				if (lim > 4)
					lim = 4;
				k   = i + 1 + rand_below(lim);
				arg = cpu_pkg::byte_t'(2 * k);
			end
			default: begin
			end
		endcase
		// Low nibble of the opcode byte is don't care
		b = rand_byte();
		prog_mem[2 * i]     = {op, b[3:0]};
		prog_mem[2 * i + 1] = arg;
	end
	b = rand_byte();
	if (end_illegal)
		op = b[4] ? 4'hf : 4'he;
	else
		op = cpu_pkg::hlt;
	prog_mem[2 * (n - 1)]     = {op, b[3:0]};
	prog_mem[2 * (n - 1) + 1] = rand_byte();
endfunction

// **************************************************************************
// Reference model
// **************************************************************************

function automatic cpu_pkg::byte_t model_read(input cpu_pkg::byte_t a);
	exp_bus.push_back({1'b1, a, 8'h00});
	return model_mem[a];
endfunction

function automatic void model_write(input cpu_pkg::byte_t a, input cpu_pkg::byte_t d);
	exp_bus.push_back({1'b0, a, d});
	model_mem[a] = d;
	exp_writes++;
endfunction

function automatic void run_model();
	cpu_pkg::byte_t pc;
	cpu_pkg::byte_t acc;
	cpu_pkg::byte_t x;
	cpu_pkg::byte_t arg;
	cpu_pkg::byte_t d;
	logic [3:0]     op;
	logic           z;
	logic           c;
	logic           done;
	int             step;
	exp_bus.delete();
	exp_writes = 0;
	exp_error  = 1'b0;
	for (step = 0; step < 256; step++)
		model_mem[step] = prog_mem[step];
	pc   = 8'h00;
	acc  = 8'h00;
	x    = 8'h00;
	z    = 1'b0;
	c    = 1'b0;
	done = 1'b0;
	for (step = 0; step < 256 && !done; step++) begin
		d  = model_read(pc);
		op = d[7:4];
		pc = pc + 8'd1;
		// Codes past hlt trap before the operand is read
		if (op > cpu_pkg::hlt) begin
			exp_error = 1'b1;
			done      = 1'b1;
		end else begin
			arg = model_read(pc);
			pc  = pc + 8'd1;
			case (op)
				cpu_pkg::lda_imm: acc = arg;
				cpu_pkg::lda_mem: acc = model_read(arg);
				cpu_pkg::lda_idx: acc = model_read(arg + x);
				cpu_pkg::sta_mem: model_write(arg, acc);
				cpu_pkg::stx_mem: model_write(arg, x);
				cpu_pkg::add_mem: begin
					// Carry when the true sum leaves the byte range
					d   = model_read(arg);
					c   = (int'(acc) + int'(d)) > 255;
					acc = acc + d;
				end
				cpu_pkg::sub_mem: begin
					// Carry means no borrow
					d   = model_read(arg);
					c   = (acc >= d);
					acc = acc - d;
				end
				cpu_pkg::and_mem: begin
					acc = acc & model_read(arg);
					c   = 1'b0;
				end
				cpu_pkg::xor_mem: begin
					acc = acc ^ model_read(arg);
					c   = 1'b0;
				end
				cpu_pkg::ldx_imm: x = arg;
				cpu_pkg::jmp: pc = arg;
				cpu_pkg::jz: pc = z ? arg : pc;
				cpu_pkg::jc: pc = c ? arg : pc;
				default: done = 1'b1;
			endcase
			// Zero follows every accumulator load
			case (op)
				cpu_pkg::lda_imm, cpu_pkg::lda_mem, cpu_pkg::lda_idx, cpu_pkg::add_mem,
				cpu_pkg::sub_mem, cpu_pkg::and_mem, cpu_pkg::xor_mem: z = (acc == 8'h00);
				default: begin
				end
			endcase
		end
	end
endfunction

`endif

// ==== tb/tb_cpu.sv ====
// **************************************************************************
// Testbench for the microprogrammed 8-bit CPU
// Runs random programs against an instruction-level model and checks each
// bus cycle, the halt and error status and the final memory
// **************************************************************************

`timescale 1ns/1ps

module tb_cpu;

	localparam int period_ns    = 40;
	localparam int drive_dly    = 2;
	localparam int reset_cycles = 4;
	localparam int n_tests      = 12;
	localparam int n_instr      = 40;
	// At most three cycles per instruction
	localparam int run_limit    = n_instr * 3 + 4;
	localparam int test_cycles  = run_limit + reset_cycles + 8;
	localparam int watchdog_ns  = n_tests * test_cycles * period_ns + 2000;

	logic           clock;
	logic           arst_n;
	cpu_pkg::byte_t data_in;
	logic           vma;
	logic           r_w;
	cpu_pkg::byte_t addr;
	cpu_pkg::byte_t data_out;
	logic           halted;
	logic           error;

	cpu_pkg::byte_t mem [0:255];
	logic           running;
	int             writes_seen;
	int             byte_errors;
	int             write_errors;
	int             bit_errors;
	int             other_errors;

	`include "tb_cpu_model.svh"

	cpu_top dut0 (
		.clock    (clock),
		.arst_n   (arst_n),
		.data_in  (data_in),
		.vma      (vma),
		.r_w      (r_w),
		.addr     (addr),
		.data_out (data_out),
		.halted   (halted),
		.error    (error)
	);

	always #(period_ns / 2) clock = ~clock;

	// **********************************************************************
	// Memory model
	// **********************************************************************

	// Reads answer combinationally, writes land on the edge
	assign data_in = mem[addr];

	always @(posedge clock) begin
		if (vma && !r_w)
			mem[addr] = data_out;
	end

	// **********************************************************************
	// Checks
	// **********************************************************************

	task automatic check_byte(input string name, input cpu_pkg::byte_t got,
		input cpu_pkg::byte_t expected);
		if (got !== expected) begin
			byte_errors++;
			$display("Error: %0t ns: %s is %02h, expected %02h", $time, name, got, expected);
		end
	endtask

	task automatic check_write(input cpu_pkg::byte_t got_a, input cpu_pkg::byte_t got_d,
		input cpu_pkg::byte_t exp_a, input cpu_pkg::byte_t exp_d);
		if (got_a !== exp_a || got_d !== exp_d) begin
			write_errors++;
			$display("Error: %0t ns: write addr/data_out is %02h/%02h, expected %02h/%02h",
				$time, got_a, got_d, exp_a, exp_d);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic expected);
		if (got !== expected) begin
			bit_errors++;
			$display("Error: %0t ns: %s is %b, expected %b", $time, name, got, expected);
		end
	endtask

	task automatic report_failure(input string what);
		other_errors++;
		$display("Error: %0t ns: %s", $time, what);
	endtask

	// Bus monitor, mid-cycle so strobes and addr have settled
	always @(negedge clock) begin : monitor
		logic [16:0] cyc;
		if (running && vma) begin
			if (halted)
				report_failure("bus cycle while the CPU is halted");
			if (!r_w)
				writes_seen++;
			if (exp_bus.size() == 0) begin
				report_failure("bus cycle past the end of the expected sequence");
			end else begin
				cyc = exp_bus.pop_front();
				check_bit("r_w", r_w, cyc[16]);
				if (cyc[16])
					check_byte("addr", addr, cyc[15:8]);
				else
					check_write(addr, data_out, cyc[15:8], cyc[7:0]);
			end
		end
	end

	// **********************************************************************
	// Test sequence
	// **********************************************************************

	task automatic run_test(input int t);
		int cycles;
		int a;
		@(posedge clock);
		#drive_dly;
		arst_n = 1'b0;
		gen_program(n_instr, (t % 4) == 3);
		for (a = 0; a < 256; a++)
			mem[a] = prog_mem[a];
		run_model();
		writes_seen = 0;
		repeat (reset_cycles) @(posedge clock);
		#drive_dly;
		// Idle bus and clear status under reset
		check_bit("vma", vma, 1'b0);
		check_bit("r_w", r_w, 1'b1);
		check_bit("halted", halted, 1'b0);
		check_bit("error", error, 1'b0);
		arst_n  = 1'b1;
		running = 1'b1;
		cycles  = 0;
		while (!halted && cycles < run_limit) begin
			@(posedge clock);
			#drive_dly;
			cycles++;
		end
		if (!halted)
			report_failure($sformatf("test %0d: CPU did not halt in %0d cycles", t, run_limit));
		// A few idle cycles, the monitor flags any bus activity
		repeat (4) @(posedge clock);
		#drive_dly;
		check_bit("halted", halted, 1'b1);
		check_bit("error", error, exp_error);
		if (exp_bus.size() != 0)
			report_failure($sformatf("test %0d: %0d expected bus cycles never came", t,
				exp_bus.size()));
		if (writes_seen != exp_writes) begin
			other_errors++;
			$display("Error: %0t ns: write count is %0d, expected %0d", $time, writes_seen,
				exp_writes);
		end
		for (a = 0; a < 256; a++)
			check_byte($sformatf("mem[%02h]", a), mem[a], model_mem[a]);
		running = 1'b0;
	endtask

	initial begin : main
		int a;
		int t;
		clock        = 1'b0;
		arst_n       = 1'b0;
		running      = 1'b0;
		writes_seen  = 0;
		byte_errors  = 0;
		write_errors = 0;
		bit_errors   = 0;
		other_errors = 0;
		lcg_state    = lcg_seed;
		for (a = 0; a < 256; a++)
			mem[a] = cpu_pkg::byte_t'(a) ^ 8'h5a;
		for (t = 0; t < n_tests; t++)
			run_test(t);
		$display("Errors: byte %0d, write %0d, status %0d, other %0d",
			byte_errors, write_errors, bit_errors, other_errors);
		if (byte_errors + write_errors + bit_errors + other_errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	// Watchdog sized from the test count and the instruction budget
	initial begin : watchdog
		#(watchdog_ns);
		$display("Error: %0t ns: watchdog expired before the tests finished", $time);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== src/cpu_top.sv ====
// **************************************************************************
// Microprogrammed 8-bit CPU top level
// Connects control, program control and arithmetic blocks to the memory
// port with split data in and data out
// **************************************************************************

`timescale 1ns/1ps

module cpu_top (
	input  logic              clock,
	input  logic              arst_n,
	input  cpu_pkg::byte_t    data_in,
	output logic              vma,
	output logic              r_w,
	output cpu_pkg::byte_t    addr,
	output cpu_pkg::byte_t    data_out,
	output logic              halted,
	output logic              error
);

	// Control strobes
	logic                  pc_inc;
	logic                  pc_load;
	logic                  arg_load;
	logic                  x_load;
	logic                  x_store;
	logic                  acc_load;
	cpu_pkg::addr_sel_t    addr_sel;
	cpu_pkg::alu_mode_t    alu_mode;

	// Datapath results
	cpu_pkg::byte_t        acc;
	cpu_pkg::byte_t        x_reg;
	logic                  zero;
	logic                  carry;

	// Control unit
	cpu_ccu u_ccu (
		.clock    (clock),
		.arst_n   (arst_n),
		.data_in  (data_in),
		.zero     (zero),
		.carry    (carry),
		.vma      (vma),
		.r_w      (r_w),
		.pc_inc   (pc_inc),
		.pc_load  (pc_load),
		.arg_load (arg_load),
		.x_load   (x_load),
		.x_store  (x_store),
		.addr_sel (addr_sel),
		.alu_mode (alu_mode),
		.acc_load (acc_load),
		.halted   (halted),
		.error    (error)
	);

	// Program control unit
	cpu_pcu u_pcu (
		.clock    (clock),
		.arst_n   (arst_n),
		.data_in  (data_in),
		.pc_inc   (pc_inc),
		.pc_load  (pc_load),
		.arg_load (arg_load),
		.x_load   (x_load),
		.addr_sel (addr_sel),
		.addr     (addr),
		.x_reg    (x_reg)
	);

	// Arithmetic block
	cpu_alu u_alu (
		.clock    (clock),
		.arst_n   (arst_n),
		.data_in  (data_in),
		.alu_mode (alu_mode),
		.acc_load (acc_load),
		.acc      (acc),
		.zero     (zero),
		.carry    (carry)
	);

	// Store data, index for stx_mem, accumulator otherwise
	assign data_out = x_store ? x_reg : acc;

endmodule

// ==== src/cpu_ccu.sv ====
// **************************************************************************
// CPU control unit
// Holds the instruction register and the microcode sequencer, decodes each
// step into memory strobes and datapath controls, and traps hlt and
// illegal opcodes
// **************************************************************************

`timescale 1ns/1ps

module cpu_ccu (
	input  logic                  clock,
	input  logic                  arst_n,
	input  cpu_pkg::byte_t        data_in,
	input  logic                  zero,
	input  logic                  carry,
	output logic                  vma,
	output logic                  r_w,
	output logic                  pc_inc,
	output logic                  pc_load,
	output logic                  arg_load,
	output logic                  x_load,
	output logic                  x_store,
	output cpu_pkg::addr_sel_t    addr_sel,
	output cpu_pkg::alu_mode_t    alu_mode,
	output logic                  acc_load,
	output logic                  halted,
	output logic                  error
);

	// Opcode reads into the ALU, all other opcodes pass
	function automatic cpu_pkg::alu_mode_t mode_of(input cpu_pkg::opcode_t op);
		cpu_pkg::alu_mode_t mode;
		case (op)
			cpu_pkg::add_mem: mode = cpu_pkg::alu_add;
			cpu_pkg::sub_mem: mode = cpu_pkg::alu_sub;
			cpu_pkg::and_mem: mode = cpu_pkg::alu_and;
			cpu_pkg::xor_mem: mode = cpu_pkg::alu_xor;
			default:          mode = cpu_pkg::alu_pass;
		endcase
		return mode;
	endfunction

	// Step that follows fetch_arg for a given opcode
	function automatic cpu_pkg::uop_t after_arg(input cpu_pkg::opcode_t op);
		cpu_pkg::uop_t step;
		case (op)
			cpu_pkg::lda_mem, cpu_pkg::lda_idx,
			cpu_pkg::add_mem, cpu_pkg::sub_mem,
			cpu_pkg::and_mem, cpu_pkg::xor_mem: step = cpu_pkg::exec_read;
			cpu_pkg::sta_mem, cpu_pkg::stx_mem: step = cpu_pkg::exec_write;
			cpu_pkg::hlt:                       step = cpu_pkg::halt_state;
			default:                            step = cpu_pkg::fetch_op;
		endcase
		return step;
	endfunction

	logic               active;
	cpu_pkg::uop_t      uop;
	cpu_pkg::opcode_t   ir;
	cpu_pkg::opcode_t   op_in;
	logic               op_legal;
	logic               ir_cond;

	// Opcode field of the byte on the bus during fetch_op
	assign op_in = cpu_pkg::opcode_t'(data_in[cpu_pkg::data_w-1 -: cpu_pkg::op_w]);

	// Defined opcodes are contiguous up to hlt
	assign op_legal = (op_in <= cpu_pkg::hlt);

	// Jump condition, resolved against flags left by earlier instructions
	assign ir_cond = (ir == cpu_pkg::jmp) ||
		((ir == cpu_pkg::jz) && zero) ||
		((ir == cpu_pkg::jc) && carry);

	// **********************************************************************
	// Sequencer
	// **********************************************************************

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			active <= 1'b0;
			uop    <= cpu_pkg::fetch_op;
			ir     <= cpu_pkg::lda_imm;
			halted <= 1'b0;
			error  <= 1'b0;
		end else if (!active) begin
			// First edge out of reset starts the fetch at address 0
			active <= 1'b1;
		end else begin
			case (uop)
				cpu_pkg::fetch_op: begin
					ir <= op_in;
					if (op_legal) begin
						uop <= cpu_pkg::fetch_arg;
					end else begin
						// Trap straight away, operand byte never read
						uop    <= cpu_pkg::halt_state;
						halted <= 1'b1;
						error  <= 1'b1;
					end
				end
				cpu_pkg::fetch_arg: begin
					uop <= after_arg(ir);
					if (ir == cpu_pkg::hlt)
						halted <= 1'b1;
				end
				cpu_pkg::exec_read, cpu_pkg::exec_write: begin
					uop <= cpu_pkg::fetch_op;
				end
				default: begin
					uop <= cpu_pkg::halt_state;
				end
			endcase
		end
	end

	// **********************************************************************
	// Step decode
	// **********************************************************************

	always_comb begin
		vma      = 1'b0;
		r_w      = 1'b1;
		pc_inc   = 1'b0;
		pc_load  = 1'b0;
		arg_load = 1'b0;
		x_load   = 1'b0;
		x_store  = 1'b0;
		addr_sel = cpu_pkg::sel_pc;
		alu_mode = cpu_pkg::alu_pass;
		acc_load = 1'b0;
		if (active) begin
			case (uop)
				cpu_pkg::fetch_op: begin
					vma    = 1'b1;
					pc_inc = 1'b1;
				end
				cpu_pkg::fetch_arg: begin
					vma      = 1'b1;
					arg_load = 1'b1;
					// Taken jump replaces the increment
					pc_load  = ir_cond;
					pc_inc   = !ir_cond;
					acc_load = (ir == cpu_pkg::lda_imm);
					x_load   = (ir == cpu_pkg::ldx_imm);
				end
				cpu_pkg::exec_read: begin
					vma      = 1'b1;
					addr_sel = (ir == cpu_pkg::lda_idx) ? cpu_pkg::sel_idx : cpu_pkg::sel_arg;
					alu_mode = mode_of(ir);
					acc_load = 1'b1;
				end
				cpu_pkg::exec_write: begin
					vma      = 1'b1;
					r_w      = 1'b0;
					addr_sel = cpu_pkg::sel_arg;
					x_store  = (ir == cpu_pkg::stx_mem);
				end
				default: begin
					// halt_state, bus stays idle
				end
			endcase
		end
	end

	// Once halted the CPU never touches memory again
	a_halt_quiet: assert property (@(posedge clock) disable iff (!arst_n)
		halted |=> halted && (uop == cpu_pkg::halt_state) && !vma);

endmodule

// ==== src/cpu_pcu.sv ====
// **************************************************************************
// CPU program control unit
// Program counter, index register and operand latch, plus the memory
// address multiplexer
// **************************************************************************

`timescale 1ns/1ps

module cpu_pcu (
	input  logic                  clock,
	input  logic                  arst_n,
	input  cpu_pkg::byte_t        data_in,
	input  logic                  pc_inc,
	input  logic                  pc_load,
	input  logic                  arg_load,
	input  logic                  x_load,
	input  cpu_pkg::addr_sel_t    addr_sel,
	output cpu_pkg::byte_t        addr,
	output cpu_pkg::byte_t        x_reg
);

	cpu_pkg::byte_t pc;
	cpu_pkg::byte_t arg;

	// **********************************************************************
	// Program counter and index register
	// **********************************************************************

	// PC steps past each fetched byte
	// Jump target comes straight off the bus in fetch_arg
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			pc <= '0;
		end else if (pc_load) begin
			pc <= data_in;
		end else if (pc_inc) begin
			pc <= pc + cpu_pkg::byte_t'(1);
		end
	end

	// Index register, loaded by ldx_imm only
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			x_reg <= '0;
		end else if (x_load) begin
			x_reg <= data_in;
		end
	end

	// Operand byte, held through the exec step
	always_ff @(posedge clock) begin
		if (arg_load)
			arg <= data_in;
	end

	// **********************************************************************
	// Address select
	// **********************************************************************

	always_comb begin
		case (addr_sel)
			cpu_pkg::sel_arg: addr = arg;
			// Indexed address wraps inside the 256-byte space
			cpu_pkg::sel_idx: addr = arg + x_reg;
			default:          addr = pc;
		endcase
	end

	// A jump and an index load never share a fetch_arg
	a_pc_x_excl: assert property (@(posedge clock) disable iff (!arst_n)
		!(pc_load && x_load));

	// Load and increment never arrive together, the load would mask the step
	a_pc_onehot: assert property (@(posedge clock) disable iff (!arst_n)
		!(pc_load && pc_inc));

	// Operand is not overwritten while an exec step still needs it
	a_arg_hold: assert property (@(posedge clock) disable iff (!arst_n)
		arg_load |=> !arg_load);

endmodule

// ==== src/cpu_alu.sv ====
// **************************************************************************
// CPU arithmetic block
// Accumulator, zero and carry flags, and the ALU operations on acc and
// the memory data byte
// **************************************************************************

`timescale 1ns/1ps

module cpu_alu (
	input  logic                  clock,
	input  logic                  arst_n,
	input  cpu_pkg::byte_t        data_in,
	input  cpu_pkg::alu_mode_t    alu_mode,
	input  logic                  acc_load,
	output cpu_pkg::byte_t        acc,
	output logic                  zero,
	output logic                  carry
);

	// One extra bit for the carry out
	logic [cpu_pkg::data_w:0] sum;
	cpu_pkg::byte_t           result;
	logic                     carry_next;

	// **********************************************************************
	// Operation select
	// **********************************************************************

	always_comb begin
		sum        = '0;
		result     = data_in;
		carry_next = carry;
		case (alu_mode)
			cpu_pkg::alu_add: begin
				sum        = {1'b0, acc} + {1'b0, data_in};
				result     = sum[cpu_pkg::data_w-1:0];
				carry_next = sum[cpu_pkg::data_w];
			end
			cpu_pkg::alu_sub: begin
				// Two's complement subtract, carry set means no borrow
				sum        = {1'b0, acc} + {1'b0, ~data_in} +
					{{cpu_pkg::data_w{1'b0}}, 1'b1};
				result     = sum[cpu_pkg::data_w-1:0];
				carry_next = sum[cpu_pkg::data_w];
			end
			cpu_pkg::alu_and: begin
				result     = acc & data_in;
				carry_next = 1'b0;
			end
			cpu_pkg::alu_xor: begin
				result     = acc ^ data_in;
				carry_next = 1'b0;
			end
			default: begin
				// Pass for loads, carry kept
				result     = data_in;
				carry_next = carry;
			end
		endcase
	end

	// **********************************************************************
	// Accumulator and flags
	// **********************************************************************

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			acc   <= '0;
			zero  <= 1'b0;
			carry <= 1'b0;
		end else if (acc_load) begin
			acc   <= result;
			zero  <= (result == '0);
			carry <= carry_next;
		end
	end

endmodule

// ==== src/cpu_pkg.sv ====
// **************************************************************************
// Shared definitions for the microprogrammed 8-bit CPU
// Widths, opcodes, ALU modes, address sources and microcode steps
// **************************************************************************

package cpu_pkg;

	// Data and address bus width
	localparam int data_w = 8;

	// Opcode field sits in the upper nibble of the first byte
	localparam int op_w = 4;

	// Basic bus word
	typedef logic [data_w-1:0] byte_t;

	// **********************************************************************
	// Instruction set
	// **********************************************************************

	// Codes 4'he and 4'hf are left unassigned and trap as illegal
	typedef enum logic [op_w-1:0] {
		lda_imm = 4'h0,
		lda_mem = 4'h1,
		lda_idx = 4'h2,
		sta_mem = 4'h3,
		stx_mem = 4'h4,
		add_mem = 4'h5,
		sub_mem = 4'h6,
		and_mem = 4'h7,
		xor_mem = 4'h8,
		ldx_imm = 4'h9,
		jmp     = 4'ha,
		jz      = 4'hb,
		jc      = 4'hc,
		hlt     = 4'hd
	} opcode_t;

	// **********************************************************************
	// Datapath controls
	// **********************************************************************

	// ALU operation applied to acc and data_in
	typedef enum logic [2:0] {
		alu_pass,
		alu_add,
		alu_sub,
		alu_and,
		alu_xor
	} alu_mode_t;

	// Memory address source
	typedef enum logic [1:0] {
		sel_pc,
		sel_arg,
		sel_idx
	} addr_sel_t;

	// Microcode steps
	// Every instruction runs fetch_op and fetch_arg, memory ops add one more
	typedef enum logic [2:0] {
		fetch_op,
		fetch_arg,
		exec_read,
		exec_write,
		halt_state
	} uop_t;

endpackage
